// File: mips_pipe.f
+incdir+source
source/mips_pipe_pkg.sv
source/forward_if.sv
source/stage_reg.sv
source/decode_unit.sv
source/reg_file.sv
source/forward_unit.sv
source/alu.sv
source/mips_pipe_top.sv
verification/mips_pipe_tb.sv

// File: verification/mips_pipe_tb.sv
/*
 * core testbench: clock, reset, instruction and data memories, program build,
 * reference model with load delay slot, store comparison and watchdog
 */
`include "mips_pipe_defines.svh"

module mips_pipe_tb import mips_pipe_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] text_start = `MIPS_TEXT_START;
   localparam logic [29:0] text_base  = text_start[31:2];

   logic        clk = 1'b0;
   logic        rst_b;
   logic [29:0] inst_addr;
   word_t       inst;
   logic [29:0] mem_addr;
   word_t       store_data;
   word_t       load_data;
   logic [3:0]  mem_write_en;

   word_t       prog [$];
   word_t       dmem [0:63];
   word_t       model_regs [0:31];
   word_t       model_mem [0:63];
   logic [29:0] exp_addr [$];
   word_t       exp_data [$];
   int          exp_cyc [$];
   logic        pend_valid;
   reg_addr_t   pend_reg;
   word_t       pend_val;
   logic [31:0] lfsr = 32'h87806a39;
   logic        prog_ready = 1'b0;
   int          cyc = 0;
   logic        st_pend = 1'b0;
   logic [5:0]  st_idx;
   word_t       st_word;

   mips_pipe_top dut_i (.clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .mem_addr(mem_addr), .store_data(store_data), .load_data(load_data),
      .mem_write_en(mem_write_en));

   always #50 clk = ~clk;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_failure("value mismatch");
      end
   endtask

   // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
   function automatic word_t rand_bits(input int n);
      word_t v;
      logic  fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rs,
                                    input reg_addr_t rt, input reg_addr_t rd,
                                    input logic [4:0] sh);
      return {`MIPS_OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // registers 0..7 only, memory ops on base r0 with aligned offsets
   function automatic word_t random_inst();
      logic [3:0]  kind;
      reg_addr_t   rs;
      reg_addr_t   rt;
      reg_addr_t   rd;
      logic [4:0]  sh;
      logic [15:0] imm;
      logic [15:0] off;
      logic [5:0]  fn;
      kind = 4'(rand_bits(4));
      rs   = 5'(rand_bits(3));
      rt   = 5'(rand_bits(3));
      rd   = 5'(rand_bits(3));
      sh   = 5'(rand_bits(5));
      imm  = 16'(rand_bits(16));
      off  = {8'h00, 6'(rand_bits(6)), 2'b00};
      case (kind[2:0])
         3'd0: fn = `MIPS_FN_ADDU;
         3'd1: fn = `MIPS_FN_SUBU;
         3'd2: fn = `MIPS_FN_AND;
         3'd3: fn = `MIPS_FN_OR;
         3'd4: fn = `MIPS_FN_XOR;
         3'd5: fn = `MIPS_FN_SLL;
         3'd6: fn = `MIPS_FN_SRL;
         default: fn = `MIPS_FN_SRA;
      endcase
      case (kind)
         4'd8:  return i_type(`MIPS_OP_ADDIU, rs, rt, imm);
         4'd9:  return i_type(`MIPS_OP_ANDI, rs, rt, imm);
         4'd10: return i_type(`MIPS_OP_ORI, rs, rt, imm);
         4'd11: return i_type(`MIPS_OP_XORI, rs, rt, imm);
         4'd12, 4'd13: return i_type(`MIPS_OP_LW, 5'd0, rt, off);
         4'd14, 4'd15: return i_type(`MIPS_OP_SW, 5'd0, rt, off);
         default: return r_type(fn, rs, rt, rd, sh);
      endcase
   endfunction

   // one instruction in program order, returns 1 with the store it makes
   function automatic logic ref_exec(input word_t ins, output logic [29:0] st_addr,
                                     output word_t st_data);
      logic [5:0] op;
      reg_addr_t  rt;
      reg_addr_t  wreg;
      logic [4:0] sh;
      word_t      a;
      word_t      b;
      word_t      sext;
      word_t      zext;
      word_t      addr;
      word_t      res;
      logic       wr;
      logic       is_load;
      logic       is_store;
      op       = ins[31:26];
      rt       = ins[20:16];
      sh       = ins[10:6];
      a        = model_regs[ins[25:21]];
      b        = model_regs[rt];
      sext     = {{16{ins[15]}}, ins[15:0]};
      zext     = {16'h0000, ins[15:0]};
      addr     = a + sext;
      wr       = 1'b1;
      wreg     = rt;
      res      = '0;
      is_load  = 1'b0;
      is_store = 1'b0;
      st_addr  = addr[31:2];
      st_data  = b;
      case (op)
         `MIPS_OP_SPECIAL: begin
            wreg = ins[15:11];
            case (ins[5:0])
               `MIPS_FN_ADDU: res = a + b;
               `MIPS_FN_SUBU: res = a - b;
               `MIPS_FN_AND:  res = a & b;
               `MIPS_FN_OR:   res = a | b;
               `MIPS_FN_XOR:  res = a ^ b;
               `MIPS_FN_SLL:  res = b << sh;
               `MIPS_FN_SRL:  res = b >> sh;
               `MIPS_FN_SRA:  res = $signed(b) >>> sh;
               default:       wr = 1'b0;
            endcase
         end
         `MIPS_OP_ADDIU: res = a + sext;
         `MIPS_OP_ANDI:  res = a & zext;
         `MIPS_OP_ORI:   res = a | zext;
         `MIPS_OP_XORI:  res = a ^ zext;
         `MIPS_OP_LW: begin
            wr      = 1'b0;
            is_load = 1'b1;
            res     = model_mem[addr[7:2]];
         end
         `MIPS_OP_SW: begin
            wr       = 1'b0;
            is_store = 1'b1;
            model_mem[addr[7:2]] = b;
         end
         default: wr = 1'b0;
      endcase
      // previous load lands only after this instruction read its operands
      if (pend_valid && pend_reg != '0) model_regs[pend_reg] = pend_val;
      pend_valid = is_load;
      pend_reg   = rt;
      pend_val   = res;
      if (wr && wreg != '0) model_regs[wreg] = res;
      return is_store;
   endfunction

   task automatic build_program();
      // dependent chain through execute and memory stage bypass
      prog.push_back(i_type(`MIPS_OP_ORI, 5'd0, 5'd1, 16'h1234));
      prog.push_back(i_type(`MIPS_OP_ADDIU, 5'd1, 5'd2, 16'hfffb));
      prog.push_back(r_type(`MIPS_FN_ADDU, 5'd2, 5'd1, 5'd3, 5'd0));
      prog.push_back(r_type(`MIPS_FN_XOR, 5'd3, 5'd2, 5'd4, 5'd0));
      prog.push_back(r_type(`MIPS_FN_SUBU, 5'd4, 5'd1, 5'd5, 5'd0));
      prog.push_back(i_type(`MIPS_OP_ANDI, 5'd5, 5'd6, 16'hff0f));
      prog.push_back(r_type(`MIPS_FN_OR, 5'd6, 5'd5, 5'd7, 5'd0));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd7, 16'h0000));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd5, 16'h0004));
      // writer three ahead, undefined opcode, writes to r0
      prog.push_back(i_type(`MIPS_OP_ORI, 5'd0, 5'd7, 16'hbeef));
      prog.push_back(i_type(6'h3f, 5'd0, 5'd7, 16'h1111));
      prog.push_back(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'h0055));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd7, 16'h0008));
      prog.push_back(i_type(`MIPS_OP_ORI, 5'd0, 5'd0, 16'h7777));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd0, 16'h000c));
      prog.push_back(r_type(`MIPS_FN_ADDU, 5'd0, 5'd0, 5'd1, 5'd0));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd1, 16'h0010));
      // load use with delay slot, then load data bypass and shifts
      prog.push_back(i_type(`MIPS_OP_LW, 5'd0, 5'd2, 16'h0014));
      prog.push_back(r_type(`MIPS_FN_ADDU, 5'd2, 5'd2, 5'd3, 5'd0));
      prog.push_back(r_type(`MIPS_FN_ADDU, 5'd2, 5'd0, 5'd4, 5'd0));
      prog.push_back(r_type(`MIPS_FN_SLL, 5'd0, 5'd4, 5'd5, 5'd3));
      prog.push_back(r_type(`MIPS_FN_SRA, 5'd0, 5'd5, 5'd6, 5'd7));
      prog.push_back(r_type(`MIPS_FN_SRL, 5'd0, 5'd4, 5'd7, 5'd29));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd3, 16'h0018));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd4, 16'h001c));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd6, 16'h0020));
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd7, 16'h0024));
      prog.push_back(i_type(`MIPS_OP_LW, 5'd0, 5'd1, 16'h0000));
      prog.push_back('0);
      prog.push_back(i_type(`MIPS_OP_SW, 5'd0, 5'd1, 16'h0028));
      for (int n = 0; n < 200; n++) begin
         prog.push_back(random_inst());
      end
   endtask

   // beyond the program the fetch sees zero, a no-op
   function automatic word_t fetch_word(input logic [29:0] addr);
      logic [29:0] off;
      off = addr - text_base;
      return (off < prog.size()) ? prog[off] : '0;
   endfunction

   // memories answer 1 ns after the edge, pending store committed first
   always @(posedge clk) begin
      #1;
      if (st_pend) begin
         dmem[st_idx] = st_word;
         st_pend      = 1'b0;
      end
      inst      = fetch_word(inst_addr);
      load_data = dmem[mem_addr[5:0]];
   end

   // mid-cycle sampling of fetch address and store port
   always @(negedge clk) begin
      if (!rst_b) begin
         check_value("mem_write_en", mem_write_en, '0);
         check_value("inst_addr", inst_addr, text_base);
      end else begin
         check_value("inst_addr", inst_addr, text_base + cyc);
         if (cyc < 3) check_value("mem_write_en", mem_write_en, '0);
         if (mem_write_en != '0) begin
            if (exp_addr.size() == 0) begin
               stop_with_failure("store seen after the last expected store");
            end else begin
               check_value("mem_write_en", mem_write_en, 32'hf);
               check_value("mem_addr", mem_addr, exp_addr[0]);
               check_value("store_data", store_data, exp_data[0]);
               check_value("store cycle", cyc, exp_cyc[0]);
               void'(exp_addr.pop_front());
               void'(exp_data.pop_front());
               void'(exp_cyc.pop_front());
               st_pend = 1'b1;
               st_idx  = mem_addr[5:0];
               st_word = store_data;
            end
         end
         cyc = cyc + 1;
      end
   end

   initial begin
      int limit_ns;
      wait (prog_ready);
      limit_ns = (prog.size() + 20) * 100;
      #(limit_ns);
      stop_with_failure($sformatf("run did not finish within %0d ns", limit_ns));
   end

   initial begin
      logic [29:0] st_addr;
      word_t       st_data;
      rst_b     = 1'b0;
      inst      = '0;
      load_data = '0;
      // fill depends on the whole word index
      for (int i = 0; i < 64; i++) begin
         dmem[i]      = 32'ha5000000 ^ (i * 32'h9e3779b9);
         model_mem[i] = dmem[i];
      end
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      pend_valid = 1'b0;
      build_program();
      // a store fetched in cycle k shows up in cycle k+3
      for (int k = 0; k < prog.size(); k++) begin
         if (ref_exec(prog[k], st_addr, st_data)) begin
            exp_addr.push_back(st_addr);
            exp_data.push_back(st_data);
            exp_cyc.push_back(k + 3);
         end
      end
      prog_ready = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst_b = 1'b1;
      while (cyc < prog.size() + 4) @(posedge clk);
      if (exp_addr.size() != 0) begin
         stop_with_failure($sformatf("%0d expected stores never appeared", exp_addr.size()));
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// File: source/mips_pipe_top.sv
/*
 * five-stage core top: pc and fetch register, decode with bypass,
 * execute, memory ports and writeback select
 */
`include "mips_pipe_defines.svh"

module mips_pipe_top import mips_pipe_pkg::*; (
   input  logic        clk,
   input  logic        rst_b,
   output logic [29:0] inst_addr,
   input  word_t       inst,
   output logic [29:0] mem_addr,
   output word_t       store_data,
   input  word_t       load_data,
   output logic [3:0]  mem_write_en
);

   word_t        pc;
   word_t        id_inst;
   ctrl_t        id_ctrl;
   alu_op_t      id_alu_op;
   logic         id_use_imm;
   word_t        id_imm;
   reg_addr_t    id_rs;
   reg_addr_t    id_rt;
   reg_addr_t    id_dest;
   word_t        rs_data;
   word_t        rt_data;
   word_t        op_a;
   word_t        op_b;
   ex_payload_t  id_out;
   ex_payload_t  ex_in;
   word_t        alu_b;
   word_t        alu_result;
   mem_payload_t ex_out;
   mem_payload_t mem_in;
   wb_payload_t  mem_out;
   wb_payload_t  wb_in;
   word_t        wb_data;

   forward_if fwd_bus ();

   // fetch, one word per cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc      <= `MIPS_TEXT_START;
         id_inst <= '0;
      end else begin
         pc      <= pc + 32'd4;
         id_inst <= inst;
      end
   end
   assign inst_addr = pc[31:2];

   // decode and operand read
   decode_unit decode_i (.inst(id_inst), .ctrl(id_ctrl), .alu_op(id_alu_op),
      .use_imm(id_use_imm), .imm(id_imm), .rs(id_rs), .rt(id_rt), .dest(id_dest));
   reg_file reg_file_i (.clk(clk), .rst_b(rst_b), .rs(id_rs), .rt(id_rt),
      .rs_data(rs_data), .rt_data(rt_data), .wr_en(wb_in.ctrl.reg_we),
      .wr_addr(wb_in.dest), .wr_data(wb_data));
   forward_unit forward_i (.fwd(fwd_bus.sink), .rs(id_rs), .rt(id_rt),
      .rs_data(rs_data), .rt_data(rt_data), .op_a(op_a), .op_b(op_b));
   assign id_out = '{ctrl: id_ctrl, alu_op: id_alu_op, use_imm: id_use_imm,
      op_a: op_a, op_b: op_b, imm: id_imm, dest: id_dest};
   stage_reg #(.payload_t(ex_payload_t)) id_ex_reg (.clk(clk), .rst_b(rst_b),
      .d(id_out), .q(ex_in));

   // execute, shamt taken from the immediate
   assign alu_b = ex_in.use_imm ? ex_in.imm : ex_in.op_b;
   alu alu_i (.op(ex_in.alu_op), .a(ex_in.op_a), .b(alu_b), .shamt(ex_in.imm[4:0]),
      .result(alu_result));
   assign ex_out = '{ctrl: ex_in.ctrl, alu_result: alu_result,
      store_data: ex_in.op_b, dest: ex_in.dest};
   stage_reg #(.payload_t(mem_payload_t)) ex_mem_reg (.clk(clk), .rst_b(rst_b),
      .d(ex_out), .q(mem_in));

   // memory stage, word address from result bits 31:2
   assign mem_addr     = mem_in.alu_result[31:2];
   assign store_data   = mem_in.store_data;
   assign mem_write_en = {4{mem_in.ctrl.mem_write}};
   assign mem_out = '{ctrl: mem_in.ctrl, alu_result: mem_in.alu_result,
      load_data: load_data, dest: mem_in.dest};
   stage_reg #(.payload_t(wb_payload_t)) mem_wb_reg (.clk(clk), .rst_b(rst_b),
      .d(mem_out), .q(wb_in));

   // writeback
   assign wb_data = wb_in.ctrl.mem_read ? wb_in.load_data : wb_in.alu_result;

   // a load in execute only has its address, so the next instruction
   // sees the older value (load delay slot)
   assign fwd_bus.ex_we      = ex_in.ctrl.reg_we && !ex_in.ctrl.mem_read;
   assign fwd_bus.ex_dest    = ex_in.dest;
   assign fwd_bus.ex_result  = alu_result;
   assign fwd_bus.mem_we     = mem_in.ctrl.reg_we;
   assign fwd_bus.mem_read   = mem_in.ctrl.mem_read;
   assign fwd_bus.mem_dest   = mem_in.dest;
   assign fwd_bus.mem_result = mem_in.alu_result;
   assign fwd_bus.load_data  = load_data;

endmodule

// File: source/alu.sv
/*
 * add, subtract, bitwise logic and shifts of b by shamt
 */
module alu import mips_pipe_pkg::*; (
   input  alu_op_t    op,
   input  word_t      a,
   input  word_t      b,
   input  logic [4:0] shamt,
   output word_t      result
);

   always_comb begin
      case (op)
         // wrapping arithmetic, no overflow trap
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_SLL: result = b << shamt;
         ALU_SRL: result = b >> shamt;
         // sign bit copied in
         ALU_SRA: result = word_t'($signed(b) >>> shamt);
         default: result = a + b;
      endcase
   end

endmodule

// File: source/forward_unit.sv
/*
 * per-operand bypass select from execute, memory and register file
 */
module forward_unit import mips_pipe_pkg::*; (
   forward_if.sink fwd,
   input  reg_addr_t rs,
   input  reg_addr_t rt,
   input  word_t     rs_data,
   input  word_t     rt_data,
   output word_t     op_a,
   output word_t     op_b
);

   // youngest writer first, r0 never bypassed
   function automatic word_t pick(reg_addr_t src, word_t rf_data);
      word_t value;
      logic  ex_hit;
      logic  mem_hit;
      ex_hit  = fwd.ex_we && fwd.ex_dest == src && src != '0;
      mem_hit = fwd.mem_we && fwd.mem_dest == src && src != '0;
      if (ex_hit) begin
         value = fwd.ex_result;
      end else if (mem_hit && !fwd.mem_read) begin
         value = fwd.mem_result;
      end else if (mem_hit) begin
         // load in memory stage, data is arriving this cycle
         value = fwd.load_data;
      end else begin
         // covers writeback through the file's own bypass
         value = rf_data;
      end
      return value;
   endfunction

   always_comb begin
      op_a = pick(rs, rs_data);
      op_b = pick(rt, rt_data);
   end

endmodule

// File: source/reg_file.sv
/*
 * 31 general registers, r0 reads zero, write data bypassed to reads
 */
module reg_file import mips_pipe_pkg::*; (
   input  logic      clk,
   input  logic      rst_b,
   input  reg_addr_t rs,
   input  reg_addr_t rt,
   output word_t     rs_data,
   output word_t     rt_data,
   input  logic      wr_en,
   input  reg_addr_t wr_addr,
   input  word_t     wr_data
);

   // no storage for r0
   word_t regs [1:31];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_addr != '0) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // same-cycle writeback is visible to decode
   function automatic word_t read_port(reg_addr_t addr);
      word_t data;
      if (addr == '0) begin
         data = '0;
      end else if (wr_en && addr == wr_addr) begin
         data = wr_data;
      end else begin
         data = regs[addr];
      end
      return data;
   endfunction

   always_comb begin
      rs_data = read_port(rs);
      rt_data = read_port(rt);
   end

endmodule

// File: source/decode_unit.sv
/*
 * instruction field split, control and alu op decode,
 * immediate forming and destination register select
 */
`include "mips_pipe_defines.svh"

module decode_unit import mips_pipe_pkg::*; (
   input  word_t     inst,
   output ctrl_t     ctrl,
   output alu_op_t   alu_op,
   output logic      use_imm,
   output word_t     imm,
   output reg_addr_t rs,
   output reg_addr_t rt,
   output reg_addr_t dest
);

   logic [5:0]  opcode;
   logic [5:0]  funct;
   reg_addr_t   rd;
   logic [4:0]  shamt;
   logic [15:0] imm16;
   word_t       imm_sext;
   word_t       imm_zext;
   word_t       imm_shamt;

   assign opcode = inst[31:26];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign shamt  = inst[10:6];
   assign funct  = inst[5:0];
   assign imm16  = inst[15:0];

   // three immediate flavours
   assign imm_sext  = {{(`MIPS_WORD_W-16){imm16[15]}}, imm16};
   assign imm_zext  = {{(`MIPS_WORD_W-16){1'b0}}, imm16};
   assign imm_shamt = {{(`MIPS_WORD_W-5){1'b0}}, shamt};

   // R-type writes rd, everything else rt
   assign dest = (opcode == `MIPS_OP_SPECIAL) ? rd : rt;

   always_comb begin
      // default is a no-op, nothing written
      ctrl    = '0;
      alu_op  = ALU_ADD;
      use_imm = 1'b0;
      imm     = imm_sext;
      case (opcode)
         `MIPS_OP_SPECIAL: begin
            ctrl.reg_we = 1'b1;
            case (funct)
               `MIPS_FN_ADDU: alu_op = ALU_ADD;
               `MIPS_FN_SUBU: alu_op = ALU_SUB;
               `MIPS_FN_AND:  alu_op = ALU_AND;
               `MIPS_FN_OR:   alu_op = ALU_OR;
               `MIPS_FN_XOR:  alu_op = ALU_XOR;
               // shifts keep rt on operand b, amount rides in imm
               `MIPS_FN_SLL: begin
                  alu_op = ALU_SLL;
                  imm    = imm_shamt;
               end
               `MIPS_FN_SRL: begin
                  alu_op = ALU_SRL;
                  imm    = imm_shamt;
               end
               `MIPS_FN_SRA: begin
                  alu_op = ALU_SRA;
                  imm    = imm_shamt;
               end
               default: ctrl.reg_we = 1'b0;
            endcase
         end
         `MIPS_OP_ADDIU: begin
            ctrl.reg_we = 1'b1;
            use_imm     = 1'b1;
         end
         `MIPS_OP_ANDI: begin
            ctrl.reg_we = 1'b1;
            use_imm     = 1'b1;
            alu_op      = ALU_AND;
            imm         = imm_zext;
         end
         `MIPS_OP_ORI: begin
            ctrl.reg_we = 1'b1;
            use_imm     = 1'b1;
            alu_op      = ALU_OR;
            imm         = imm_zext;
         end
         `MIPS_OP_XORI: begin
            ctrl.reg_we = 1'b1;
            use_imm     = 1'b1;
            alu_op      = ALU_XOR;
            imm         = imm_zext;
         end
         // address is base plus signed offset
         `MIPS_OP_LW: begin
            ctrl.reg_we   = 1'b1;
            ctrl.mem_read = 1'b1;
            use_imm       = 1'b1;
         end
         `MIPS_OP_SW: begin
            ctrl.mem_write = 1'b1;
            use_imm        = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

endmodule

// File: source/stage_reg.sv
/*
 * pipeline stage register for any packed payload, clears to a bubble
 */
module stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_b,
   input  payload_t d,
   output payload_t q
);

   // no enable, the pipe never stalls
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         // zero payload has no write enables set
         q <= '0;
      end else begin
         q <= d;
      end
   end

endmodule

// File: source/forward_if.sv
/*
 * in-flight writer info from execute and memory stages for operand bypass
 */
`include "mips_pipe_defines.svh"

interface forward_if #(
   parameter int word_w = `MIPS_WORD_W,
   parameter int reg_aw = `MIPS_REG_AW
) ();
   // instruction currently in execute
   logic              ex_we;
   logic [reg_aw-1:0] ex_dest;
   logic [word_w-1:0] ex_result;
   // instruction currently in memory
   logic              mem_we;
   logic              mem_read;
   logic [reg_aw-1:0] mem_dest;
   logic [word_w-1:0] mem_result;
   logic [word_w-1:0] load_data;

   modport source (
      output ex_we, ex_dest, ex_result,
      output mem_we, mem_read, mem_dest, mem_result, load_data
   );
   modport sink (
      input ex_we, ex_dest, ex_result,
      input mem_we, mem_read, mem_dest, mem_result, load_data
   );
endinterface

// File: source/mips_pipe_pkg.sv
/*
 * shared types: data word, register number, alu operations,
 * control bits and the three pipeline stage payloads
 */
`include "mips_pipe_defines.svh"

package mips_pipe_pkg;

   typedef logic [`MIPS_WORD_W-1:0] word_t;
   typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

   // shifts act on operand b
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_t;

   // all zero means bubble
   typedef struct packed {
      logic reg_we;
      logic mem_read;
      logic mem_write;
   } ctrl_t;

   // decode to execute
   typedef struct packed {
      ctrl_t     ctrl;
      alu_op_t   alu_op;
      logic      use_imm;
      word_t     op_a;
      word_t     op_b;
      word_t     imm;
      reg_addr_t dest;
   } ex_payload_t;

   // execute to memory, store_data is the forwarded rt
   typedef struct packed {
      ctrl_t     ctrl;
      word_t     alu_result;
      word_t     store_data;
      reg_addr_t dest;
   } mem_payload_t;

   // memory to writeback
   typedef struct packed {
      ctrl_t     ctrl;
      word_t     alu_result;
      word_t     load_data;
      reg_addr_t dest;
   } wb_payload_t;

endpackage

// File: source/mips_pipe_defines.svh
/*
 * widths, reset pc, opcode and funct encodings of the integer subset
 */
`ifndef MIPS_PIPE_DEFINES_SVH
`define MIPS_PIPE_DEFINES_SVH

// datapath widths
`define MIPS_WORD_W 32
`define MIPS_REG_AW 5

// first text address after reset
`define MIPS_TEXT_START 32'h00400000

// primary opcodes, inst[31:26]
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

// funct codes under SPECIAL, inst[5:0]
`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_SRA  6'h03
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26

`endif
